// ==== sim/softmc_tests.txt ====
// word = tag digit + 8 payload digits. tags: 1 new test, 2 push instruction,
// 3 dfi cmd {phase,cmd,bank,0,addr}, 4 write byte, 5 pop readback byte, 6 idle cycles,
// 7 idle status {empty,full,processing}, 8 iq_full seen, 9 read commands issued
// cmd digit is {ras_n,cas_n,we_n}: act 3, pre 2, ref 1, rd 5, wr 4
// 1 reset state
100000001 700000100
// 2 command encoding on both phases, wait before the read
100000002 212000012 252A50040 200000008 242000040 222000000 230000000 260000000
303100012 314100040 315100040 302100000 301000000
4000000A5 5000000A5 60000000A 700000100
// 3 write data latency and byte replication
100000003 214000100 2543C0008 254C30009 260000000
303200100 314200008 314200009 40000003C 4000000C3 60000000A 700000100
// 4 readback in issue order
100000004 216000777 256110001 256220002 256330003 200000008
246000002 246000001 246000003 260000000
500000022 500000011 500000033 60000000A 700000100
// 5 queue back-pressure behind a long wait
100000005 20000003C 210000001 220000000 212000002 222000000 214000003 224000000
216000004 226000000 218000005 228000000 260000000 800000000
303000001 302000000 303100002 302100000 303200003 302200000 303300004 302300000
303400005 302400000 60000000A 700000100
// 6 credit stall, one further read per pop
100000006 21A000042 24A000000 24A000001 24A000002 24A000003 24A000004 24A000005
260000000 60000001E 900000004 500000000 60000000A 900000005
500000000 60000000A 900000006
500000000 500000000 500000000 500000000 60000000A 700000100

// ==== project.f ====
source/softmc_pkg.sv
source/instr_queue.sv
source/iseq_executor.sv
source/dfi_cmd_encoder.sv
source/rdback_fifo.sv
source/softmc_top.sv
sim/tb_clock_gen.sv
sim/softmc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module softmc_tb -f project.f -o softmc_sim

out=$(./obj_dir/softmc_sim)
echo "$out"

if grep -qF '*** TEST PASSED ***' <<< "$out"; then
	exit 0
else
	exit 1
fi

// ==== sim/softmc_tb.sv ====
`default_nettype none

module softmc_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import softmc_pkg::*;

	localparam int DQ_WIDTH = 16;
	localparam int IQ_DEPTH = 8;
	localparam int RB_DEPTH = 4;
	localparam int WR_LAT = 5;
	localparam int BURST_BYTES = 4 * DQ_WIDTH / 8;
	localparam int MAX_RECS = 256;
	localparam int WAIT_LIMIT = 200; // cycles for any single handshake

	logic clk;
	logic reset;
	logic app_en;
	logic [INSTR_WIDTH-1:0] app_instr;
	logic app_ack;
	logic iq_full;
	logic processing_iseq;
	logic rdback_fifo_empty;
	logic rdback_fifo_rden;
	logic [4*DQ_WIDTH-1:0] rdback_data;
	logic [ROW_WIDTH-1:0] dfi_address0;
	logic [ROW_WIDTH-1:0] dfi_address1;
	logic [BANK_WIDTH-1:0] dfi_bank0;
	logic [BANK_WIDTH-1:0] dfi_bank1;
	logic dfi_ras_n0;
	logic dfi_cas_n0;
	logic dfi_we_n0;
	logic dfi_cs_n0;
	logic dfi_ras_n1;
	logic dfi_cas_n1;
	logic dfi_we_n1;
	logic dfi_cs_n1;
	logic dfi_rddata_en;
	logic dfi_wrdata_en;
	logic [4*DQ_WIDTH-1:0] dfi_wrdata;
	logic [4*DQ_WIDTH-1:0] dfi_rddata;
	logic dfi_rddata_valid;

	logic [35:0] recs [MAX_RECS]; // tag nibble + payload
	int limit_cycles = 0;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_id = 0;
	int test_err0 = 0;
	int rd_count = 0;
	int rd_base = 0;
	int full_cycles = 0;
	int full_base = 0;
	int last_due = 0;
	logic prev_full = 1'b0;
	logic prev_busy = 1'b0;
	logic [31:0] cmd_seen [$]; // same layout as the tests file
	int wr_delay [$];
	logic [4*DQ_WIDTH-1:0] wr_data [$];
	int wr_cycle [$];
	logic [34:0] wr_key [$];
	int rd_due [$];
	logic [34:0] rd_key [$];
	logic [ROW_WIDTH-1:0] open_row [8];
	logic [7:0] dram [bit [34:0]]; // byte per {bank, row, column}

	tb_clock_gen clk_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	softmc_top #(
		.DQ_WIDTH (DQ_WIDTH),
		.IQ_DEPTH (IQ_DEPTH),
		.RB_DEPTH (RB_DEPTH),
		.WR_LAT   (WR_LAT)
	) dut_i (.*);

	task automatic note_error(input string what);
		errors++;
		$display("%0t ns: %s", $time, what);
	endtask

	task automatic compare(input string sig, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, sig, got, exp);
		end
	endtask

	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic push_instr(input logic [31:0] instr);
		int n;
		n = 0;
		app_en = 1'b1;
		app_instr = instr;
		do begin
			step(1);
			n++;
		end while (!app_ack && n < WAIT_LIMIT);
		app_en = 1'b0;
		if (!app_ack)
			note_error($sformatf("instruction %h was never acknowledged", instr));
	endtask

	task automatic expect_cmd(input logic [31:0] exp);
		int n;
		n = 0;
		while (cmd_seen.size() == 0 && n < WAIT_LIMIT) begin
			step(1);
			n++;
		end
		if (cmd_seen.size() == 0)
			note_error($sformatf("DFI command %h never appeared", exp));
		else
			compare("dfi phase/cmd/bank/address", cmd_seen.pop_front(), exp);
	endtask

	task automatic expect_wrdata(input logic [7:0] b);
		int n;
		n = 0;
		while (wr_data.size() == 0 && n < WAIT_LIMIT) begin
			step(1);
			n++;
		end
		if (wr_data.size() == 0) begin
			note_error("no write data burst appeared");
		end else begin
			compare("dfi_wrdata_en latency", wr_delay.pop_front(), WR_LAT);
			compare("dfi_wrdata", wr_data.pop_front(), {BURST_BYTES{b}});
		end
	endtask

	task automatic pop_readback(input logic [7:0] b);
		int n;
		n = 0;
		while (rdback_fifo_empty && n < WAIT_LIMIT) begin
			step(1);
			n++;
		end
		if (rdback_fifo_empty) begin
			note_error("readback FIFO stayed empty");
		end else begin
			compare("rdback_data", rdback_data, {BURST_BYTES{b}});
			rdback_fifo_rden = 1'b1;
			step(1);
			rdback_fifo_rden = 1'b0;
		end
	endtask

	// quiet DUT with status bits from the record
	task automatic check_idle(input logic [31:0] p);
		compare("processing_iseq", processing_iseq, p[0]);
		compare("iq_full", iq_full, p[4]);
		compare("rdback_fifo_empty", rdback_fifo_empty, p[8]);
		compare("app_ack", app_ack, 1'b0);
		compare("dfi_cs_n0/1", {dfi_cs_n0, dfi_cs_n1}, 2'b11);
		compare("phase 0 ras/cas/we", {dfi_ras_n0, dfi_cas_n0, dfi_we_n0}, 3'b111);
		compare("phase 1 ras/cas/we", {dfi_ras_n1, dfi_cas_n1, dfi_we_n1}, 3'b111);
		compare("dfi_rddata_en/wrdata_en", {dfi_rddata_en, dfi_wrdata_en}, 2'b00);
	endtask

	task automatic close_test();
		if (tests > 0) begin
			if (errors == test_err0) begin
				$display("test %0d done, no errors", test_id);
			end else begin
				failed_tests++;
				$display("test %0d done, %0d errors", test_id, errors - test_err0);
			end
		end
	endtask

	task automatic run_record(input logic [3:0] tag, input logic [31:0] p);
		case (tag)
			4'h1: begin
				close_test();
				tests++;
				test_id = p;
				test_err0 = errors;
				rd_base = rd_count;
				full_base = full_cycles;
				cmd_seen.delete();
				wr_delay.delete();
				wr_data.delete();
			end
			4'h2: push_instr(p);
			4'h3: expect_cmd(p);
			4'h4: expect_wrdata(p[7:0]);
			4'h5: pop_readback(p[7:0]);
			4'h6: step(p);
			4'h7: check_idle(p);
			4'h8: compare("iq_full seen during test", full_cycles > full_base, 1'b1);
			4'h9: compare("read commands issued", rd_count - rd_base, p);
			default: note_error($sformatf("unknown record tag %h in tests file", tag));
		endcase
	endtask

	// DRAM model and DFI monitor just after each rising edge
	always @(posedge clk) begin
		logic [34:0] key;
		logic [2:0] cmd0;
		logic [2:0] cmd1;
		int due;
		#2;
		cycle++;
		dfi_rddata_valid = 1'b0;
		if (!reset) begin
			cmd0 = {dfi_ras_n0, dfi_cas_n0, dfi_we_n0};
			cmd1 = {dfi_ras_n1, dfi_cas_n1, dfi_we_n1};
			assert (!(app_ack && prev_full)) else note_error("app_ack given while queue full");
			prev_full = iq_full;
			if (iq_full)
				full_cycles++;
			// the pop two cycles back has already raised processing_iseq
			if (!dfi_cs_n0 || !dfi_cs_n1)
				compare("processing_iseq", prev_busy, 1'b1);
			prev_busy = processing_iseq;
			if (dfi_cs_n0)
				compare("phase 0 nop", cmd0, 3'b111);
			else
				cmd_seen.push_back({4'd0, 1'b0, cmd0, 1'b0, dfi_bank0, 4'd0, dfi_address0});
			if (!dfi_cs_n0 && cmd0 == 3'b011)
				open_row[dfi_bank0] = dfi_address0; // activate opens the row
			if (dfi_cs_n1)
				compare("phase 1 nop", cmd1, 3'b111);
			else
				cmd_seen.push_back({4'd1, 1'b0, cmd1, 1'b0, dfi_bank1, 4'd0, dfi_address1});
			key = {dfi_bank1, open_row[dfi_bank1], dfi_address1};
			compare("dfi_rddata_en", dfi_rddata_en, !dfi_cs_n1 && cmd1 == 3'b101);
			if (!dfi_cs_n1 && cmd1 == 3'b101) begin
				rd_count++;
				due = cycle + $urandom_range(8, 3);
				if (due <= last_due)
					due = last_due + 1; // bursts return in order
				last_due = due;
				rd_due.push_back(due);
				rd_key.push_back(key);
			end
			if (!dfi_cs_n1 && cmd1 == 3'b100) begin
				wr_cycle.push_back(cycle);
				wr_key.push_back(key);
			end
			if (dfi_wrdata_en) begin
				if (wr_cycle.size() == 0) begin
					note_error("write data burst without a write command");
				end else begin
					wr_delay.push_back(cycle - wr_cycle.pop_front());
					wr_data.push_back(dfi_wrdata);
					dram[wr_key.pop_front()] = dfi_wrdata[7:0];
				end
			end
			// lookup at return time so late write data lands first
			if (rd_due.size() != 0 && rd_due[0] <= cycle) begin
				void'(rd_due.pop_front());
				key = rd_key.pop_front();
				dfi_rddata = {BURST_BYTES{dram.exists(key) ? dram[key] : 8'h00}};
				dfi_rddata_valid = 1'b1;
			end
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, run did not finish", limit_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int idx;
		app_en = 1'b0;
		app_instr = '0;
		rdback_fifo_rden = 1'b0;
		dfi_rddata = '0;
		dfi_rddata_valid = 1'b0;
		void'($urandom(47));
		foreach (open_row[i])
			open_row[i] = '0;
		foreach (recs[i])
			recs[i] = '0; // zero tag ends the list
		$readmemh("sim/softmc_tests.txt", recs);
		idx = 0;
		while (idx < MAX_RECS && recs[idx][35:32] != 4'h0)
			idx++;
		if (idx == 0)
			note_error("tests file holds no records");
		limit_cycles = idx * 40;
		wait (reset === 1'b0);
		step(1);
		idx = 0;
		while (idx < MAX_RECS && recs[idx][35:32] != 4'h0) begin
			run_record(recs[idx][35:32], recs[idx][31:0]);
			idx++;
		end
		close_test();
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 reset = 1'b0; // released just after the edge
	end

endmodule

`default_nettype wire

// ==== source/softmc_top.sv ====
`default_nettype none

module softmc_top #(
	parameter int DQ_WIDTH = 16,
	parameter int IQ_DEPTH = 8,
	parameter int RB_DEPTH = 4,
	parameter int WR_LAT   = 5
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               app_en,
	input  logic [softmc_pkg::INSTR_WIDTH-1:0] app_instr,
	output logic                               app_ack,
	output logic                               iq_full,
	output logic                               processing_iseq,
	output logic                               rdback_fifo_empty,
	input  logic                               rdback_fifo_rden,
	output logic [4*DQ_WIDTH-1:0]              rdback_data,
	output logic [softmc_pkg::ROW_WIDTH-1:0]   dfi_address0,
	output logic [softmc_pkg::ROW_WIDTH-1:0]   dfi_address1,
	output logic [softmc_pkg::BANK_WIDTH-1:0]  dfi_bank0,
	output logic [softmc_pkg::BANK_WIDTH-1:0]  dfi_bank1,
	output logic                               dfi_ras_n0,
	output logic                               dfi_ras_n1,
	output logic                               dfi_cas_n0,
	output logic                               dfi_cas_n1,
	output logic                               dfi_we_n0,
	output logic                               dfi_we_n1,
	output logic                               dfi_cs_n0,
	output logic                               dfi_cs_n1,
	output logic                               dfi_rddata_en,
	output logic                               dfi_wrdata_en,
	output logic [4*DQ_WIDTH-1:0]              dfi_wrdata,
	input  logic [4*DQ_WIDTH-1:0]              dfi_rddata,
	input  logic                               dfi_rddata_valid
);
	import softmc_pkg::*;

	logic iq_valid;
	logic [INSTR_WIDTH-1:0] iq_instr;
	logic iq_pop;
	logic credit_return;
	logic cmd_valid;
	opcode_t cmd_op;
	logic [BANK_WIDTH-1:0] cmd_bank;
	logic [ROW_WIDTH-1:0] cmd_addr;
	logic [WBYTE_WIDTH-1:0] cmd_wbyte;

	instr_queue #(
		.IQ_DEPTH (IQ_DEPTH)
	) iq_i (
		.clk       (clk),
		.reset     (reset),
		.app_en    (app_en),
		.app_instr (app_instr),
		.app_ack   (app_ack),
		.iq_full   (iq_full),
		.iq_pop    (iq_pop),
		.iq_valid  (iq_valid),
		.iq_instr  (iq_instr)
	);

	iseq_executor #(
		.RB_DEPTH (RB_DEPTH)
	) exec_i (
		.clk             (clk),
		.reset           (reset),
		.iq_valid        (iq_valid),
		.iq_instr        (iq_instr),
		.iq_pop          (iq_pop),
		.credit_return   (credit_return),
		.processing_iseq (processing_iseq),
		.cmd_valid       (cmd_valid),
		.cmd_op          (cmd_op),
		.cmd_bank        (cmd_bank),
		.cmd_addr        (cmd_addr),
		.cmd_wbyte       (cmd_wbyte)
	);

	dfi_cmd_encoder #(
		.DQ_WIDTH (DQ_WIDTH),
		.WR_LAT   (WR_LAT)
	) enc_i (
		.clk           (clk),
		.reset         (reset),
		.cmd_valid     (cmd_valid),
		.cmd_op        (cmd_op),
		.cmd_bank      (cmd_bank),
		.cmd_addr      (cmd_addr),
		.cmd_wbyte     (cmd_wbyte),
		.dfi_address0  (dfi_address0),
		.dfi_address1  (dfi_address1),
		.dfi_bank0     (dfi_bank0),
		.dfi_bank1     (dfi_bank1),
		.dfi_ras_n0    (dfi_ras_n0),
		.dfi_ras_n1    (dfi_ras_n1),
		.dfi_cas_n0    (dfi_cas_n0),
		.dfi_cas_n1    (dfi_cas_n1),
		.dfi_we_n0     (dfi_we_n0),
		.dfi_we_n1     (dfi_we_n1),
		.dfi_cs_n0     (dfi_cs_n0),
		.dfi_cs_n1     (dfi_cs_n1),
		.dfi_rddata_en (dfi_rddata_en),
		.dfi_wrdata_en (dfi_wrdata_en),
		.dfi_wrdata    (dfi_wrdata)
	);

	rdback_fifo #(
		.DQ_WIDTH (DQ_WIDTH),
		.RB_DEPTH (RB_DEPTH)
	) rb_i (
		.clk               (clk),
		.reset             (reset),
		.dfi_rddata        (dfi_rddata),
		.dfi_rddata_valid  (dfi_rddata_valid),
		.rdback_fifo_rden  (rdback_fifo_rden),
		.rdback_data       (rdback_data),
		.rdback_fifo_empty (rdback_fifo_empty),
		.credit_return     (credit_return)
	);

endmodule

`default_nettype wire

// ==== source/rdback_fifo.sv ====
`default_nettype none

module rdback_fifo #(
	parameter int DQ_WIDTH = 16,
	parameter int RB_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [4*DQ_WIDTH-1:0] dfi_rddata,
	input  logic                  dfi_rddata_valid,
	input  logic                  rdback_fifo_rden,
	output logic [4*DQ_WIDTH-1:0] rdback_data,
	output logic                  rdback_fifo_empty,
	output logic                  credit_return
);

	localparam int PTR_W = (RB_DEPTH > 1) ? $clog2(RB_DEPTH) : 1;
	localparam int CNT_W = $clog2(RB_DEPTH + 1);

	logic [4*DQ_WIDTH-1:0] mem [RB_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(RB_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// credits in the executor keep this from overflowing
	assign push = dfi_rddata_valid;
	assign pop = rdback_fifo_rden && !rdback_fifo_empty;

	assign rdback_fifo_empty = (count == '0);
	assign rdback_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= pop; // slot freed
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= dfi_rddata;
	end

endmodule

`default_nettype wire

// ==== source/dfi_cmd_encoder.sv ====
`default_nettype none

module dfi_cmd_encoder #(
	parameter int DQ_WIDTH = 16,
	parameter int WR_LAT   = 5
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               cmd_valid,
	input  softmc_pkg::opcode_t                cmd_op,
	input  logic [softmc_pkg::BANK_WIDTH-1:0]  cmd_bank,
	input  logic [softmc_pkg::ROW_WIDTH-1:0]   cmd_addr,
	input  logic [softmc_pkg::WBYTE_WIDTH-1:0] cmd_wbyte,
	output logic [softmc_pkg::ROW_WIDTH-1:0]   dfi_address0,
	output logic [softmc_pkg::ROW_WIDTH-1:0]   dfi_address1,
	output logic [softmc_pkg::BANK_WIDTH-1:0]  dfi_bank0,
	output logic [softmc_pkg::BANK_WIDTH-1:0]  dfi_bank1,
	output logic                               dfi_ras_n0,
	output logic                               dfi_ras_n1,
	output logic                               dfi_cas_n0,
	output logic                               dfi_cas_n1,
	output logic                               dfi_we_n0,
	output logic                               dfi_we_n1,
	output logic                               dfi_cs_n0,
	output logic                               dfi_cs_n1,
	output logic                               dfi_rddata_en,
	output logic                               dfi_wrdata_en,
	output logic [4*DQ_WIDTH-1:0]              dfi_wrdata
);
	import softmc_pkg::*;

	localparam int WR_REPL = 4 * DQ_WIDTH / WBYTE_WIDTH;

	logic row_cmd;
	logic col_cmd;
	logic [CMD_WIDTH-1:0] next_cmd;
	logic [WBYTE_WIDTH-1:0] wbyte_q;
	logic wr_issued;
	logic [WR_LAT-1:0] wr_en_line;
	logic [WBYTE_WIDTH-1:0] wr_byte_line [WR_LAT];

	assign row_cmd = cmd_valid && (cmd_op inside {OP_ACT, OP_PRE, OP_REF});
	assign col_cmd = cmd_valid && (cmd_op inside {OP_READ, OP_WRITE});

	always_comb begin
		unique case (cmd_op)
			OP_ACT:   next_cmd = CMD_ACT;
			OP_PRE:   next_cmd = CMD_PRE;
			OP_REF:   next_cmd = CMD_REF;
			OP_READ:  next_cmd = CMD_RD;
			OP_WRITE: next_cmd = CMD_WR;
			default:  next_cmd = CMD_NOP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			{dfi_ras_n0, dfi_cas_n0, dfi_we_n0} <= CMD_NOP;
			{dfi_ras_n1, dfi_cas_n1, dfi_we_n1} <= CMD_NOP;
			dfi_cs_n0 <= 1'b1;
			dfi_cs_n1 <= 1'b1;
			dfi_address0 <= '0;
			dfi_address1 <= '0;
			dfi_bank0 <= '0;
			dfi_bank1 <= '0;
			dfi_rddata_en <= 1'b0;
		end else begin
			// phase 0 rows, phase 1 columns
			{dfi_ras_n0, dfi_cas_n0, dfi_we_n0} <= row_cmd ? next_cmd : CMD_NOP;
			{dfi_ras_n1, dfi_cas_n1, dfi_we_n1} <= col_cmd ? next_cmd : CMD_NOP;
			dfi_cs_n0 <= !row_cmd;
			dfi_cs_n1 <= !col_cmd;
			dfi_address0 <= row_cmd ? cmd_addr : '0;
			dfi_address1 <= col_cmd ? cmd_addr : '0;
			dfi_bank0 <= row_cmd ? cmd_bank : '0;
			dfi_bank1 <= col_cmd ? cmd_bank : '0;
			dfi_rddata_en <= cmd_valid && (cmd_op == OP_READ);
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_op == OP_WRITE)
			wbyte_q <= cmd_wbyte;
	end

	// write command currently on the pins
	assign wr_issued = !dfi_cs_n1 && ({dfi_ras_n1, dfi_cas_n1, dfi_we_n1} == CMD_WR);

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_en_line <= '0;
		end else begin
			wr_en_line[0] <= wr_issued;
			for (int i = 1; i < WR_LAT; i++)
				wr_en_line[i] <= wr_en_line[i-1];
		end
	end

	always_ff @(posedge clk) begin
		wr_byte_line[0] <= wbyte_q;
		for (int i = 1; i < WR_LAT; i++)
			wr_byte_line[i] <= wr_byte_line[i-1];
	end

	assign dfi_wrdata_en = wr_en_line[WR_LAT-1];
	assign dfi_wrdata = {WR_REPL{wr_byte_line[WR_LAT-1]}}; // byte fills the burst

endmodule

`default_nettype wire

// ==== source/iseq_executor.sv ====
`default_nettype none

module iseq_executor #(
	parameter int RB_DEPTH = 4
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               iq_valid,
	input  logic [softmc_pkg::INSTR_WIDTH-1:0] iq_instr,
	output logic                               iq_pop,
	input  logic                               credit_return,
	output logic                               processing_iseq,
	output logic                               cmd_valid,
	output softmc_pkg::opcode_t                cmd_op,
	output logic [softmc_pkg::BANK_WIDTH-1:0]  cmd_bank,
	output logic [softmc_pkg::ROW_WIDTH-1:0]   cmd_addr,
	output logic [softmc_pkg::WBYTE_WIDTH-1:0] cmd_wbyte
);
	import softmc_pkg::*;

	localparam int CRED_W = $clog2(RB_DEPTH + 1);

	opcode_t head_op;
	logic [BANK_WIDTH-1:0] head_bank;
	logic [ROW_WIDTH-1:0] head_addr;
	logic [WBYTE_WIDTH-1:0] head_wbyte;
	logic [ROW_WIDTH-1:0] wait_cnt;
	logic [CRED_W-1:0] credits;
	logic waiting;
	logic read_blocked;
	logic is_dram_cmd;
	logic spend;

	// field split of the queue head
	assign head_op = opcode_t'(iq_instr[OPC_MSB:OPC_LSB]);
	assign head_bank = iq_instr[BANK_MSB:BANK_LSB];
	assign head_addr = iq_instr[ADDR_MSB:ADDR_LSB];
	assign head_wbyte = iq_instr[WDATA_MSB:WDATA_LSB];

	assign is_dram_cmd = head_op inside {OP_ACT, OP_PRE, OP_REF, OP_READ, OP_WRITE};

	assign waiting = (wait_cnt != '0);
	// a read needs a free readback slot
	assign read_blocked = (head_op == OP_READ) && (credits == '0);

	assign iq_pop = iq_valid && !waiting && !read_blocked;
	assign spend = iq_pop && (head_op == OP_READ);

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_cnt <= '0;
		end else if (iq_pop && head_op == OP_WAIT) begin
			// pop cycle is the first wait cycle, zero behaves like one
			wait_cnt <= (head_addr == '0) ? '0 : head_addr - 1'b1;
		end else if (waiting) begin
			wait_cnt <= wait_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			credits <= CRED_W'(RB_DEPTH); // one per readback entry
		else
			credits <= credits - CRED_W'(spend) + CRED_W'(credit_return);
	end

	always_ff @(posedge clk) begin
		if (reset)
			processing_iseq <= 1'b0;
		else if (iq_pop)
			processing_iseq <= (head_op != OP_END);
	end

	always_ff @(posedge clk) begin
		if (reset)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= iq_pop && is_dram_cmd; // wait and end issue nothing
	end

	always_ff @(posedge clk) begin
		if (iq_pop) begin
			cmd_op <= head_op;
			cmd_bank <= head_bank;
			cmd_addr <= head_addr;
			cmd_wbyte <= head_wbyte;
		end
	end

endmodule

`default_nettype wire

// ==== source/instr_queue.sv ====
`default_nettype none

module instr_queue #(
	parameter int IQ_DEPTH = 8
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               app_en,
	input  logic [softmc_pkg::INSTR_WIDTH-1:0] app_instr,
	output logic                               app_ack,
	output logic                               iq_full,
	input  logic                               iq_pop,
	output logic                               iq_valid,
	output logic [softmc_pkg::INSTR_WIDTH-1:0] iq_instr
);
	import softmc_pkg::*;

	localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
	localparam int CNT_W = $clog2(IQ_DEPTH + 1);

	logic [INSTR_WIDTH-1:0] mem [IQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(IQ_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// host keeps app_en up until it sees the ack, so skip the ack cycle
	assign push = app_en && !app_ack && !iq_full;
	assign pop = iq_pop && iq_valid;

	assign iq_full = (count == CNT_W'(IQ_DEPTH));
	assign iq_valid = (count != '0);
	assign iq_instr = mem[rd_ptr]; // fall-through head

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			app_ack <= 1'b0;
		end else begin
			app_ack <= push; // single pulse
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= app_instr;
	end

endmodule

`default_nettype wire

// ==== source/softmc_pkg.sv ====
`default_nettype none

package softmc_pkg;

	localparam int INSTR_WIDTH = 32;
	localparam int OPC_WIDTH   = 4;
	localparam int ROW_WIDTH   = 16; // dram address bus
	localparam int BANK_WIDTH  = 3;
	localparam int WBYTE_WIDTH = 8;  // write pattern byte
	localparam int CMD_WIDTH   = 3;  // {ras_n, cas_n, we_n}

	// instruction word layout
	localparam int OPC_MSB   = 31;
	localparam int OPC_LSB   = 28;
	localparam int BANK_MSB  = 27;
	localparam int BANK_LSB  = 25;
	localparam int WDATA_MSB = 23; // bit 24 spare
	localparam int WDATA_LSB = 16;
	localparam int ADDR_MSB  = 15; // row, column or wait count
	localparam int ADDR_LSB  = 0;

	typedef enum logic [OPC_WIDTH-1:0] {
		OP_WAIT  = 4'h0, // idle for addr cycles
		OP_ACT   = 4'h1,
		OP_PRE   = 4'h2,
		OP_REF   = 4'h3,
		OP_READ  = 4'h4,
		OP_WRITE = 4'h5,
		OP_END   = 4'h6  // closes a sequence
	} opcode_t;

	// ddr3 truth table, cs_n driven separately
	localparam logic [CMD_WIDTH-1:0] CMD_NOP = 3'b111;
	localparam logic [CMD_WIDTH-1:0] CMD_ACT = 3'b011;
	localparam logic [CMD_WIDTH-1:0] CMD_PRE = 3'b010;
	localparam logic [CMD_WIDTH-1:0] CMD_REF = 3'b001;
	localparam logic [CMD_WIDTH-1:0] CMD_RD  = 3'b101;
	localparam logic [CMD_WIDTH-1:0] CMD_WR  = 3'b100;

endpackage

`default_nettype wire
